// File: src/fsqrt_pkg.sv
package fsqrt_pkg;

   // ieee single fields
   localparam int EXP_W    = 8;
   localparam int MAN_W    = 23;
   localparam int EXP_BIAS = 127;
   localparam int EXP_MAX  = 255;

   // aligned mantissa, 2 integer bits, 1.0 up to 4.0
   localparam int ALIGN_W = 25;

   // inverse root, all fraction bits, 0.5 to 1.0
   localparam int ROOT_W = 27;

   // seed rom
   localparam int    SEED_W     = 16;
   localparam int    SEED_DEPTH = 48;
   localparam string SEED_FILE  = "src/rsqrt_seed.hex";

   // in_valid to out_valid
   localparam int PIPE_DEPTH = 4;

   localparam int QNAN_BIT = 22;

   // newton error term, sign and 2 integer bits on top of the fraction
   localparam int ERR_F = 32;
   localparam int ERR_W = ERR_F + 3;

   typedef enum logic [2:0] {
      CLS_NORMAL,
      CLS_ZERO,
      CLS_INF,
      CLS_NAN,
      CLS_NEG
   } fsqrt_class_e;

endpackage

// File: src/fsqrt_unpack.sv
`timescale 1ns/1ps

module fsqrt_unpack (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                in_valid,
   input  logic [31:0]                         x,
   output logic                                valid,
   output fsqrt_pkg::fsqrt_class_e             cls,
   output logic                                sign,
   output logic [fsqrt_pkg::ALIGN_W-1:0]       man_a,
   output logic signed [fsqrt_pkg::EXP_W-1:0]  exp_h,
   output logic [fsqrt_pkg::ROOT_W-1:0]        root,
   output logic [fsqrt_pkg::MAN_W-1:0]         man_raw
);
   import fsqrt_pkg::*;

   logic [SEED_W-1:0]     seed_rom [SEED_DEPTH];
   logic [EXP_W-1:0]      e;
   logic [MAN_W-1:0]      m;
   logic signed [EXP_W:0] unb;
   fsqrt_class_e          cls_c;
   logic [ALIGN_W-1:0]    man_a_c;
   logic [5:0]            seed_idx;

   initial begin
      $readmemh(SEED_FILE, seed_rom);
   end

   assign e   = x[EXP_W+MAN_W-1 -: EXP_W];
   assign m   = x[MAN_W-1:0];
   assign unb = $signed({1'b0, e}) - (EXP_W+1)'(EXP_BIAS);

   // -inf falls through to negative, subnormals flush to zero
   always_comb begin
      if (e == EXP_MAX && m != '0)
         cls_c = CLS_NAN;
      else if (e == '0)
         cls_c = CLS_ZERO;
      else if (x[31])
         cls_c = CLS_NEG;
      else if (e == EXP_MAX)
         cls_c = CLS_INF;
      else
         cls_c = CLS_NORMAL;
   end

   // odd exponent gets one extra left shift
   assign man_a_c  = unb[0] ? {1'b1, m, 1'b0} : {2'b01, m};
   assign seed_idx = man_a_c[ALIGN_W-1 -: 6] - 6'd16;

   always_ff @(posedge clk) begin
      if (reset)
         valid <= 1'b0;
      else
         valid <= in_valid;
   end

   always_ff @(posedge clk) begin
      cls     <= cls_c;
      sign    <= x[31];
      man_a   <= man_a_c;
      // floor of half the unbiased exponent
      exp_h   <= unb[EXP_W:1];
      root    <= {seed_rom[seed_idx], {(ROOT_W-SEED_W){1'b0}}};
      man_raw <= m;
   end

   // seeds must lie in [0.5, 1.0)
   assert property (@(posedge clk) disable iff (reset)
      in_valid && cls_c == CLS_NORMAL |->
         seed_idx < SEED_DEPTH && seed_rom[seed_idx][SEED_W-1])
      else $error("seed index %0d beyond table or seed below 0.5", seed_idx);

endmodule

// File: src/rsqrt_newton.sv
`timescale 1ns/1ps

module rsqrt_newton (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                valid,
   input  fsqrt_pkg::fsqrt_class_e             cls,
   input  logic                                sign,
   input  logic [fsqrt_pkg::ALIGN_W-1:0]       man_a,
   input  logic signed [fsqrt_pkg::EXP_W-1:0]  exp_h,
   input  logic [fsqrt_pkg::ROOT_W-1:0]        root,
   input  logic [fsqrt_pkg::MAN_W-1:0]         man_raw,
   output logic                                q_valid,
   output fsqrt_pkg::fsqrt_class_e             q_cls,
   output logic                                q_sign,
   output logic [fsqrt_pkg::ALIGN_W-1:0]       q_man_a,
   output logic signed [fsqrt_pkg::EXP_W-1:0]  q_exp_h,
   output logic [fsqrt_pkg::ROOT_W-1:0]        q_root,
   output logic [fsqrt_pkg::MAN_W-1:0]         q_man_raw
);
   import fsqrt_pkg::*;

   logic [2*ROOT_W-1:0]              sq;
   logic [ALIGN_W+ROOT_W+3:0]        ar2;
   logic signed [ALIGN_W+ROOT_W+4:0] err;
   logic signed [ERR_W-1:0]          e_t;
   logic signed [2*ERR_W-1:0]        e_sq;
   logic signed [ERR_W-1:0]          e_sq_t;
   logic signed [ERR_W-1:0]          corr;
   logic signed [ROOT_W+ERR_W:0]     delta;
   logic signed [ROOT_W+ERR_W:0]     sum;
   logic                             inc;
   logic [ROOT_W:0]                  root_r;
   logic                             ovf;

   // e = 1 - a*r*r, products truncated
   assign sq   = root * root;
   assign ar2  = man_a * sq[2*ROOT_W-1 -: ROOT_W+4];
   assign err  = $signed({3'b001, {(ALIGN_W+ROOT_W+2){1'b0}}}) - $signed({1'b0, ar2});
   assign e_t  = err[ALIGN_W+ROOT_W+4 -: ERR_W];
   assign e_sq = e_t * e_t;
   assign e_sq_t = e_sq[ERR_F +: ERR_W];

   // r*(3 - a*r*r)/2 is r*(1 + e/2); the 3/8 e^2 term speeds convergence
   assign corr  = (e_t >>> 1) + ((e_sq_t + (e_sq_t <<< 1)) >>> 3);
   assign delta = $signed({1'b0, root}) * corr;
   assign sum   = $signed({{(ERR_W-ERR_F+1){1'b0}}, root, {ERR_F{1'b0}}}) + delta;

   // nearest even, clamp just below 1.0
   assign inc    = sum[ERR_F-1] & ((|sum[ERR_F-2:0]) | sum[ERR_F]);
   assign root_r = {1'b0, sum[ERR_F +: ROOT_W]} + (ROOT_W+1)'(inc);
   assign ovf    = (|sum[ROOT_W+ERR_W:ROOT_W+ERR_F]) | root_r[ROOT_W];

   always_ff @(posedge clk) begin
      if (reset)
         q_valid <= 1'b0;
      else
         q_valid <= valid;
   end

   always_ff @(posedge clk) begin
      q_cls     <= cls;
      q_sign    <= sign;
      q_man_a   <= man_a;
      q_exp_h   <= exp_h;
      q_root    <= ovf ? {ROOT_W{1'b1}} : root_r[ROOT_W-1:0];
      q_man_raw <= man_raw;
   end

   assert property (@(posedge clk) disable iff (reset)
      valid && cls == CLS_NORMAL |=> q_root[ROOT_W-1])
      else $error("refined root left [0.5, 1.0)");

endmodule

// File: src/fsqrt_pack.sv
`timescale 1ns/1ps

module fsqrt_pack (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                valid,
   input  fsqrt_pkg::fsqrt_class_e             cls,
   input  logic                                sign,
   input  logic [fsqrt_pkg::ALIGN_W-1:0]       man_a,
   input  logic signed [fsqrt_pkg::EXP_W-1:0]  exp_h,
   input  logic [fsqrt_pkg::ROOT_W-1:0]        root,
   input  logic [fsqrt_pkg::MAN_W-1:0]         man_raw,
   output logic [31:0]                         y,
   output logic                                exception,
   output logic                                out_valid
);
   import fsqrt_pkg::*;

   logic [ALIGN_W+ROOT_W-1:0] prod;
   logic                      top;
   logic [ALIGN_W+ROOT_W-3:0] frac_n;
   logic [MAN_W-1:0]          mant;
   logic                      guard;
   logic                      sticky;
   logic                      inc;
   logic [MAN_W:0]            mant_r;
   logic [EXP_W-1:0]          exp_b;
   logic [31:0]               y_num;
   logic [31:0]               y_c;
   logic                      exc_c;

   // sqrt(a) = a * rsqrt(a), lands just under 1.0 or in [1.0, 2.0)
   assign prod   = man_a * root;
   assign top    = prod[ALIGN_W+ROOT_W-2];
   assign frac_n = top ? prod[ALIGN_W+ROOT_W-3:0] : {prod[ALIGN_W+ROOT_W-4:0], 1'b0};

   assign mant   = frac_n[ALIGN_W+ROOT_W-3 -: MAN_W];
   assign guard  = frac_n[ALIGN_W+ROOT_W-3-MAN_W];
   assign sticky = |frac_n[ALIGN_W+ROOT_W-4-MAN_W:0];
   assign inc    = guard & (sticky | mant[0]);
   assign mant_r = {1'b0, mant} + (MAN_W+1)'(inc);

   // rounding carry bumps the exponent, mantissa bits are already zero then
   assign exp_b = EXP_W'(int'(exp_h) + EXP_BIAS - 1 + int'(top) + int'(mant_r[MAN_W]));
   assign y_num = {1'b0, exp_b, mant_r[MAN_W-1:0]};

   always_comb begin
      y_c   = y_num;
      exc_c = 1'b0;
      case (cls)
         CLS_NAN: begin
            y_c   = {sign, EXP_W'(EXP_MAX), man_raw | (MAN_W'(1) << QNAN_BIT)};
            exc_c = 1'b1;
         end
         CLS_INF: begin
            y_c = {1'b0, EXP_W'(EXP_MAX), {MAN_W{1'b0}}};
         end
         CLS_ZERO: begin
            y_c = {sign, {(EXP_W+MAN_W){1'b0}}};
         end
         CLS_NEG: begin
            // default quiet nan
            y_c   = {1'b1, EXP_W'(EXP_MAX), MAN_W'(1) << QNAN_BIT};
            exc_c = 1'b1;
         end
         default: begin
            y_c = y_num;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         y         <= '0;
         exception <= 1'b0;
      end else begin
         out_valid <= valid;
         if (valid) begin
            y         <= y_c;
            exception <= exc_c;
         end
      end
   end

   // exception marks exactly the nan results
   assert property (@(posedge clk) disable iff (reset)
      out_valid |->
         exception == (y[EXP_W+MAN_W-1 -: EXP_W] == EXP_MAX && y[MAN_W-1:0] != '0))
      else $error("exception flag disagrees with the nan encoding of y");

endmodule

// File: src/fsqrt_unit.sv
`timescale 1ns/1ps

module fsqrt_unit (
   input  logic        clk,
   input  logic        reset,
   input  logic        in_valid,
   input  logic [31:0] x,
   output logic [31:0] y,
   output logic        exception,
   output logic        out_valid
);
   import fsqrt_pkg::*;

   // s1 after unpack, s2 and s3 after each newton step
   logic                    s1_valid, s2_valid, s3_valid;
   fsqrt_class_e            s1_cls, s2_cls, s3_cls;
   logic                    s1_sign, s2_sign, s3_sign;
   logic [ALIGN_W-1:0]      s1_man_a, s2_man_a, s3_man_a;
   logic signed [EXP_W-1:0] s1_exp_h, s2_exp_h, s3_exp_h;
   logic [ROOT_W-1:0]       s1_root, s2_root, s3_root;
   logic [MAN_W-1:0]        s1_man_raw, s2_man_raw, s3_man_raw;

   fsqrt_unpack unpack_i (
      .clk(clk), .reset(reset),
      .in_valid(in_valid), .x(x),
      .valid(s1_valid), .cls(s1_cls), .sign(s1_sign),
      .man_a(s1_man_a), .exp_h(s1_exp_h),
      .root(s1_root), .man_raw(s1_man_raw)
   );

   rsqrt_newton newton1_i (
      .clk(clk), .reset(reset),
      .valid(s1_valid), .cls(s1_cls), .sign(s1_sign),
      .man_a(s1_man_a), .exp_h(s1_exp_h),
      .root(s1_root), .man_raw(s1_man_raw),
      .q_valid(s2_valid), .q_cls(s2_cls), .q_sign(s2_sign),
      .q_man_a(s2_man_a), .q_exp_h(s2_exp_h),
      .q_root(s2_root), .q_man_raw(s2_man_raw)
   );

   rsqrt_newton newton2_i (
      .clk(clk), .reset(reset),
      .valid(s2_valid), .cls(s2_cls), .sign(s2_sign),
      .man_a(s2_man_a), .exp_h(s2_exp_h),
      .root(s2_root), .man_raw(s2_man_raw),
      .q_valid(s3_valid), .q_cls(s3_cls), .q_sign(s3_sign),
      .q_man_a(s3_man_a), .q_exp_h(s3_exp_h),
      .q_root(s3_root), .q_man_raw(s3_man_raw)
   );

   fsqrt_pack pack_i (
      .clk(clk), .reset(reset),
      .valid(s3_valid), .cls(s3_cls), .sign(s3_sign),
      .man_a(s3_man_a), .exp_h(s3_exp_h),
      .root(s3_root), .man_raw(s3_man_raw),
      .y(y), .exception(exception), .out_valid(out_valid)
   );

   assert property (@(posedge clk) disable iff (reset)
      in_valid |-> ##PIPE_DEPTH out_valid)
      else $error("result missing %0d cycles after input", PIPE_DEPTH);

endmodule

// File: test/fsqrt_cases.svh
`ifndef FSQRT_CASES_SVH
`define FSQRT_CASES_SVH

// row layout {x, expected y, expected exception}
// directed rows, applied back to back
task automatic load_cases();
   // perfect squares, exact roots
   case_q.push_back({32'h3F80_0000, 32'h3F80_0000, 1'b0});
   case_q.push_back({32'h4080_0000, 32'h4000_0000, 1'b0});
   case_q.push_back({32'h4110_0000, 32'h4040_0000, 1'b0});
   case_q.push_back({32'h4180_0000, 32'h4080_0000, 1'b0});
   case_q.push_back({32'h3E80_0000, 32'h3F00_0000, 1'b0});
   case_q.push_back({32'h3D80_0000, 32'h3E80_0000, 1'b0});
   case_q.push_back({32'h4010_0000, 32'h3FC0_0000, 1'b0});
   case_q.push_back({32'h40C8_0000, 32'h4020_0000, 1'b0});
   case_q.push_back({32'h42C8_0000, 32'h4120_0000, 1'b0});
   // 2^100, 2^-100 and the smallest normal
   case_q.push_back({32'h7180_0000, 32'h5880_0000, 1'b0});
   case_q.push_back({32'h0D80_0000, 32'h2680_0000, 1'b0});
   case_q.push_back({32'h0080_0000, 32'h2000_0000, 1'b0});
   // zeros keep their sign
   case_q.push_back({32'h0000_0000, 32'h0000_0000, 1'b0});
   case_q.push_back({32'h8000_0000, 32'h8000_0000, 1'b0});
   // subnormals flush to zero
   case_q.push_back({32'h0000_0001, 32'h0000_0000, 1'b0});
   case_q.push_back({32'h007F_FFFF, 32'h0000_0000, 1'b0});
   case_q.push_back({32'h8040_0000, 32'h8000_0000, 1'b0});
   // +inf
   case_q.push_back({32'h7F80_0000, 32'h7F80_0000, 1'b0});
   // nan payload kept, quiet bit forced
   case_q.push_back({32'h7FC0_0000, 32'h7FC0_0000, 1'b1});
   case_q.push_back({32'h7FC0_0001, 32'h7FC0_0001, 1'b1});
   case_q.push_back({32'h7F80_0005, 32'h7FC0_0005, 1'b1});
   case_q.push_back({32'hFF81_2345, 32'hFFC1_2345, 1'b1});
   // negatives and -inf give the default nan
   case_q.push_back({32'hBF80_0000, 32'hFFC0_0000, 1'b1});
   case_q.push_back({32'hC080_0000, 32'hFFC0_0000, 1'b1});
   case_q.push_back({32'h8080_0000, 32'hFFC0_0000, 1'b1});
   case_q.push_back({32'hFF80_0000, 32'hFFC0_0000, 1'b1});
endtask

`endif

// File: test/fsqrt_tb.sv
`timescale 1ns/1ps

module fsqrt_tb;

   localparam int LATENCY = 4;
   localparam int TIMEOUT = 64;
   localparam logic [31:0] SEED = 32'h37e0_e98d;

   logic        clk;
   logic        reset;
   logic        in_valid;
   logic [31:0] x;
   logic [31:0] y;
   logic        exception;
   logic        out_valid;

   logic [64:0] case_q [$];
   logic [31:0] exp_y_q [$];
   logic        exp_exc_q [$];
   int          tol_q [$];
   int          in_cyc_q [$];
   int          cyc = 0;
   bit          seen_out = 0;

   `include "fsqrt_cases.svh"

   fsqrt_unit fsqrt_unit_i (
      .clk(clk), .reset(reset),
      .in_valid(in_valid), .x(x),
      .y(y), .exception(exception), .out_valid(out_valid)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   task automatic abort_run(string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(string name, logic [31:0] got, logic [31:0] expd);
      if (got !== expd)
         abort_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, expd));
   endtask

   // single to double by field widening, normal inputs only
   function automatic real to_real(logic [31:0] f);
      logic [10:0] e11;
      e11 = {3'b000, f[30:23]} + 11'd896;
      return $bitstoreal({f[31], e11, f[22:0], 29'b0});
   endfunction

   // double to single, round to nearest even
   function automatic logic [31:0] to_single(real r);
      logic [63:0] b;
      logic [7:0]  e8;
      logic        rnd;
      b   = $realtobits(r);
      e8  = 8'(b[62:52] - 11'd896);
      rnd = b[28] & ((|b[27:0]) | b[29]);
      return {b[63], e8, b[51:29]} + 32'(rnd);
   endfunction

   function automatic int ulp_dist(logic [31:0] a, logic [31:0] b);
      int d;
      d = $signed({1'b0, a[30:0]}) - $signed({1'b0, b[30:0]});
      if (a[31] != b[31])
         return 32'h7fff_ffff;
      return (d < 0) ? -d : d;
   endfunction

   task automatic drive(logic [31:0] val, logic [31:0] ey, logic ee, int tol);
      @(posedge clk);
      in_valid <= 1'b1;
      x        <= val;
      exp_y_q.push_back(ey);
      exp_exc_q.push_back(ee);
      tol_q.push_back(tol);
   endtask

   task automatic drive_random(logic [31:0] val);
      drive(val, to_single($sqrt(to_real(val))), 1'b0, 1);
   endtask

   task automatic stop_input();
      @(posedge clk);
      in_valid <= 1'b0;
      x        <= '0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_y_q.size() != 0 && waited < TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_y_q.size() != 0)
         abort_run("timeout, no result arrived for an input still in flight");
   endtask

   task automatic compare_result();
      logic [31:0] ey;
      logic        ee;
      int          tol;
      int          c;
      if (exp_y_q.size() == 0 || in_cyc_q.size() == 0) begin
         abort_run("out_valid went high with no input in flight");
      end else begin
         ey  = exp_y_q.pop_front();
         ee  = exp_exc_q.pop_front();
         tol = tol_q.pop_front();
         c   = in_cyc_q.pop_front();
         check("latency", cyc - c, LATENCY);
         check("exception", exception, ee);
         // one ulp allowed on random inputs
         if (ulp_dist(y, ey) > tol)
            check("y", y, ey);
         seen_out = 1;
      end
   endtask

   // outputs sampled mid cycle
   always @(negedge clk) begin
      if (!reset) begin
         if (in_valid)
            in_cyc_q.push_back(cyc);
         if (out_valid) begin
            compare_result();
         end else if (!seen_out) begin
            check("y", y, 32'h0);
            check("exception", exception, 32'h0);
         end
      end
   end

   initial begin
      int          seed_ret;
      int          waited;
      logic [7:0]  e;
      logic [22:0] m;
      reset    = 1'b1;
      in_valid = 1'b0;
      x        = '0;
      seed_ret = $urandom(SEED);

      repeat (4) @(posedge clk);
      reset <= 1'b0;
      // idle, nothing may come out
      repeat (8) @(posedge clk);

      load_cases();
      foreach (case_q[i])
         drive(case_q[i][64:33], case_q[i][32:1], case_q[i][0], 0);
      stop_input();
      wait_drain();

      // full rate random normals
      for (int i = 0; i < 200; i++) begin
         e = 8'(1 + $urandom % 254);
         m = 23'($urandom);
         drive_random({1'b0, e, m});
      end
      stop_input();
      wait_drain();

      // even and odd exponents at both ends of the seed table
      for (int i = 0; i < 64; i++) begin
         e = 8'(101 + 2 * ($urandom % 24) + (i % 2));
         if ((i / 2) % 2 == 0)
            m = 23'($urandom % 256);
         else
            m = 23'h7F_FFFF - 23'($urandom % 256);
         drive_random({1'b0, e, m});
      end
      stop_input();

      waited = 0;
      while (exp_y_q.size() != 0 && waited < TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_y_q.size() == 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         abort_run("timeout, no result arrived for the last inputs");
      end
   end

endmodule

// File: fsqrt_unit.f
+incdir+test
src/fsqrt_pkg.sv
src/fsqrt_unpack.sv
src/rsqrt_newton.sv
src/fsqrt_pack.sv
src/fsqrt_unit.sv
test/fsqrt_tb.sv

// File: src/rsqrt_seed.hex
FC17
F4C8
EE13
E7E4
E22A
DCD7
D7E1
D33C
CEE1
CAC8
C6EB
C345
BFD0
BC89
B96B
B673
B39F
B0EC
AE56
ABDD
A97E
A738
A508
A2EE
A0E8
9EF5
9D13
9B42
9981
97CF
962B
9494
930A
918C
9019
8EB1
8D53
8C00
8AB5
8974
883B
870A
85E2
84C1
83A7
8293
8187
8081
